// File: design/credit_counter.sv
/* Output credit counter
   Tracks downstream buffer space and permits a send while credits remain */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_config.svh"

module credit_counter (
  input  logic clk,
  input  logic rst,
  input  logic credit_return,
  input  logic out_valid,
  output logic may_send
);
  import rv_ctl_pkg::*;

  localparam credit_cnt_t MAX_CREDITS = credit_cnt_t'(`CTL_CREDITS);

  credit_cnt_t count;

  assign may_send = (count != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= MAX_CREDITS;  // Consumer buffer empty
    end else begin
      case ({credit_return, out_valid})
        2'b10: if (count < MAX_CREDITS) count <= count + 1'b1;  // Saturate at full
        2'b01: count <= count - 1'b1;
        default: count <= count;  // Return and send cancel
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/ex_stage.sv
/* Execute stage
   ALU and operand select decode, branch resolution, first pipeline register */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_config.svh"

module ex_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  output logic                in_ready,
  input  rv_ctl_pkg::ctl_in_t in,
  output logic                ex_valid,
  input  logic                ex_ready,
  output rv_ctl_pkg::ex_ctl_t ex_ctl
);
  import rv_ctl_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       f7_alt;   // funct7 bit 5, selects SUB and SRA
  logic       rs_eq;
  logic       rs_lt;
  ex_ctl_t    dec;

  assign opcode = opcode_e'(in.instr[`OPC_LSB +: 7]);
  assign funct3 = in.instr[`F3_LSB +: 3];
  assign f7_alt = in.instr[`F7_LSB + 5];
  assign rs_eq  = (in.rs1 == in.rs2);

  // Register takes a new item when empty or when wb_stage drains it
  assign in_ready = !ex_valid || ex_ready;

  always_comb begin
    dec.instr     = in.instr;
    dec.alu_op    = ALU_ADD;
    dec.a_sel_pc  = (opcode == OPC_BRANCH) || (opcode == OPC_JAL) || (opcode == OPC_AUIPC);
    dec.b_sel_imm = !((opcode == OPC_OP) || (opcode == OPC_SYSTEM));
    dec.br_un     = (opcode == OPC_BRANCH) && (funct3[2:1] == 2'b11);
    dec.br_taken  = 1'b0;

    if ((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) begin
      case (funct3)
        3'd0: dec.alu_op = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
        3'd1: dec.alu_op = ALU_SLL;
        3'd2: dec.alu_op = ALU_SLT;
        3'd3: dec.alu_op = ALU_SLTU;
        3'd4: dec.alu_op = ALU_XOR;
        3'd5: dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;  // Both OP and OP_IMM
        3'd6: dec.alu_op = ALU_OR;
        default: dec.alu_op = ALU_AND;
      endcase
    end

    // Comparator follows the decoded signedness
    if (dec.br_un) begin
      rs_lt = (in.rs1 < in.rs2);
    end else begin
      rs_lt = ($signed(in.rs1) < $signed(in.rs2));
    end

    if (opcode == OPC_BRANCH) begin
      case (funct3)
        3'd0: dec.br_taken = rs_eq;        // beq
        3'd1: dec.br_taken = !rs_eq;       // bne
        3'd4, 3'd6: dec.br_taken = rs_lt;  // blt, bltu
        3'd5, 3'd7: dec.br_taken = !rs_lt; // bge, bgeu
        default: dec.br_taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (in_ready) begin
      ex_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      ex_ctl <= dec;  // Payload, loaded on accept only
    end
  end

endmodule

`default_nettype wire

// File: design/rv_ctl_pkg.sv
/* RISC-V control decoder types
   Opcode and select encodings plus the structs passed between stages */
`default_nettype none

`include "ctl_config.svh"

package rv_ctl_pkg;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_MEM = 2'd0,
    WB_ALU = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  typedef enum logic [2:0] {
    LDX_LW  = 3'd0,
    LDX_LHU = 3'd1,
    LDX_LH  = 3'd2,
    LDX_LBU = 3'd3,
    LDX_LB  = 3'd4
  } ldx_e;

  typedef enum logic {
    PC_PLUS4 = 1'b0,
    PC_ALU   = 1'b1
  } pc_sel_e;

  // Downstream credit count, 0 up to CTL_CREDITS
  typedef logic [$clog2(`CTL_CREDITS + 1)-1:0] credit_cnt_t;

  typedef struct packed {
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] rs1;
    logic [`XLEN-1:0] rs2;
  } ctl_in_t;

  typedef struct packed {
    logic [`XLEN-1:0] instr;
    alu_op_e          alu_op;
    logic             a_sel_pc;   // Operand A is the PC
    logic             b_sel_imm;  // Operand B is the immediate
    logic             br_un;      // Unsigned compare
    logic             br_taken;
  } ex_ctl_t;

  // 16-bit control word, top bit is spare and always zero
  typedef struct packed {
    logic    spare;
    alu_op_e alu_op;
    logic    a_sel_pc;
    logic    b_sel_imm;
    logic    br_un;
    logic    br_taken;
    logic    rf_we;
    wb_sel_e wb_sel;
    ldx_e    ldx_sel;
    pc_sel_e pc_sel;
  } ctl_word_t;

endpackage

`default_nettype wire

// File: design/rv_ctl_top.sv
/* RISC-V control decoder top
   Two-stage decode pipeline with valid/ready input and credit-based output */
`timescale 1ns/1ps
`default_nettype none

module rv_ctl_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  rv_ctl_pkg::ctl_in_t   in,
  output logic                  out_valid,
  output rv_ctl_pkg::ctl_word_t out,
  input  logic                  credit_return
);
  import rv_ctl_pkg::*;

  logic    ex_valid;
  logic    ex_ready;
  ex_ctl_t ex_ctl;
  logic    may_send;

  ex_stage u_ex_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in       (in),
    .ex_valid (ex_valid),
    .ex_ready (ex_ready),
    .ex_ctl   (ex_ctl)
  );

  wb_stage u_wb_stage (
    .clk       (clk),
    .rst       (rst),
    .ex_valid  (ex_valid),
    .ex_ready  (ex_ready),
    .ex_ctl    (ex_ctl),
    .may_send  (may_send),
    .out_valid (out_valid),
    .out       (out)
  );

  // Counts sends against returned credits
  credit_counter u_credit_counter (
    .clk           (clk),
    .rst           (rst),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .may_send      (may_send)
  );

endmodule

`default_nettype wire

// File: design/wb_stage.sv
/* Writeback stage
   Writeback and next-PC decode, holds one control word until a credit allows sending */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_config.svh"

module wb_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid,
  output logic                  ex_ready,
  input  rv_ctl_pkg::ex_ctl_t   ex_ctl,
  input  logic                  may_send,
  output logic                  out_valid,
  output rv_ctl_pkg::ctl_word_t out
);
  import rv_ctl_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       word_full;
  ctl_word_t  word_d;

  assign opcode = opcode_e'(ex_ctl.instr[`OPC_LSB +: 7]);
  assign funct3 = ex_ctl.instr[`F3_LSB +: 3];

  assign out_valid = word_full && may_send;     // One credit per send
  assign ex_ready  = !word_full || out_valid;

  always_comb begin
    word_d.spare     = 1'b0;
    word_d.alu_op    = ex_ctl.alu_op;
    word_d.a_sel_pc  = ex_ctl.a_sel_pc;
    word_d.b_sel_imm = ex_ctl.b_sel_imm;
    word_d.br_un     = ex_ctl.br_un;
    word_d.br_taken  = ex_ctl.br_taken;

    case (opcode)
      OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JAL, OPC_JALR, OPC_AUIPC, OPC_LUI:
        word_d.rf_we = 1'b1;
      default:
        word_d.rf_we = 1'b0;
    endcase

    case (opcode)
      OPC_LOAD:          word_d.wb_sel = WB_MEM;
      OPC_JAL, OPC_JALR: word_d.wb_sel = WB_PC4;  // Link address
      default:           word_d.wb_sel = WB_ALU;
    endcase

    word_d.ldx_sel = LDX_LW;
    if (opcode == OPC_LOAD) begin
      case (funct3)
        3'd0: word_d.ldx_sel = LDX_LB;
        3'd1: word_d.ldx_sel = LDX_LH;
        3'd4: word_d.ldx_sel = LDX_LBU;
        3'd5: word_d.ldx_sel = LDX_LHU;
        default: word_d.ldx_sel = LDX_LW;
      endcase
    end

    // br_taken is only ever set for branches
    if ((opcode == OPC_JAL) || (opcode == OPC_JALR) || ex_ctl.br_taken) begin
      word_d.pc_sel = PC_ALU;
    end else begin
      word_d.pc_sel = PC_PLUS4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      word_full <= 1'b0;
    end else if (ex_ready) begin
      word_full <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && ex_ready) begin
      out <= word_d;
    end
  end

endmodule

`default_nettype wire

// File: dv/rv_ctl_testdata.hex
// instr    rs1      rs2      expected control word
// OP: add sub sll slt sltu xor srl sra or and
003100B3 00000005 0000000A 0050
403100B3 00000005 0000000A 0850
003110B3 00000005 0000000A 2850
003120B3 00000005 0000000A 4050
003130B3 00000005 0000000A 4850
003140B3 00000005 0000000A 2050
003150B3 00000005 0000000A 3050
403150B3 00000005 0000000A 3850
003160B3 00000005 0000000A 1850
003170B3 00000005 0000000A 1050
// OP_IMM: addi with negative imm, slli, sltiu, srli, srai
FFF10093 00000005 0000000A 0250
00311093 00000005 0000000A 2A50
00513093 00000005 0000000A 4A50
00315093 00000005 0000000A 3250
40315093 00000005 0000000A 3A50
// Branches on -1 and 1: beq bne blt bge bltu bgeu, then beq on equal values
00310463 FFFFFFFF 00000001 0610
00311463 FFFFFFFF 00000001 0691
00314463 FFFFFFFF 00000001 0691
00315463 FFFFFFFF 00000001 0610
00316463 FFFFFFFF 00000001 0710
00317463 FFFFFFFF 00000001 0791
00310463 80000000 80000000 0691
// Loads lb lh lw lbu lhu, store sw
00410083 00000100 00000000 0248
00411083 00000100 00000000 0244
00412083 00000100 00000000 0240
00414083 00000100 00000000 0246
00415083 00000100 00000000 0242
00312423 00000100 00000007 0210
// jal jalr auipc lui ecall
010000EF 00000000 00000000 0661
000100E7 00000200 00000000 0261
12345097 00000000 00000000 0650
123450B7 00000000 00000000 0250
00000073 00000000 00000000 0010

// File: dv/tb_clock.sv
/* Testbench clock
   Free-running 20 ns clock */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

endmodule

`default_nettype wire

// File: dv/tb_rv_ctl.sv
/* Control decoder testbench
   Replays file vectors under three credit return patterns and checks each output word */
`timescale 1ns/1ps
`default_nettype none

`include "ctl_config.svh"

module tb_rv_ctl;
  import rv_ctl_pkg::*;

  localparam int MAX_VEC       = 64;
  localparam int TIMEOUT       = 400;  // Cycles allowed per wait
  localparam int QUIET_CYCLES  = 8;    // Idle window that must show no extra word
  localparam int CREDIT_NONE   = 0;
  localparam int CREDIT_PROMPT = 1;
  localparam int CREDIT_RANDOM = 2;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  ctl_in_t     dut_in;
  logic        out_valid;
  ctl_word_t   dut_out;
  logic        credit_return;

  logic [31:0] vec_mem [0:4*MAX_VEC-1];  // instr, rs1, rs2, expected word
  int          num_vec;
  logic [15:0] exp_q [$];
  logic [15:0] rand_state;
  int          credit_mode;
  int          sent_count;
  int          returned_count;
  int          pending;                  // Words received and not yet credited
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  string       test_name;

  tb_clock u_clock (.clk(clk));

  rv_ctl_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in            (dut_in),
    .out_valid     (out_valid),
    .out           (dut_out),
    .credit_return (credit_return)
  );

  function automatic logic [31:0] fill_word(input int addr);
    return {16'hBAD0, addr[15:0]};
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);  // Galois form
  endfunction

  task automatic take_bit(output logic bit_out);
    rand_state = lfsr_next(rand_state);
    bit_out    = rand_state[0];
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    test_errors++;
    total_errors++;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    total_errors++;
    $display("=== FAIL ===");
    $finish;
  endtask

  // Consumer model that returns credits for words already taken
  always @(negedge clk) begin
    logic        ret_bit;
    logic [15:0] exp_word;
    credit_return = 1'b0;
    if (rst) begin
      sent_count     = 0;
      returned_count = 0;
      pending        = 0;
    end else begin
      // A return driven now lands on the same edge as this send
      if (out_valid && sent_count >= `CTL_CREDITS + returned_count) begin
        report_failure("word sent without a credit");
      end
      if (pending > 0 && credit_mode != CREDIT_NONE) begin
        ret_bit = 1'b1;
        if (credit_mode == CREDIT_RANDOM) begin
          take_bit(ret_bit);
        end
        if (ret_bit) begin
          credit_return = 1'b1;
          pending--;
          returned_count++;
        end
      end
      if (out_valid) begin
        sent_count++;
        pending++;
        if (exp_q.size() == 0) begin
          report_failure("output word arrived with no input outstanding");
        end else begin
          exp_word = exp_q.pop_front();
          check_value("control word", {16'h0, exp_word}, {16'h0, dut_out});
        end
      end
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst         = 1'b1;
    in_valid    = 1'b0;
    credit_mode = CREDIT_NONE;
    exp_q.delete();
    repeat (3) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic drive_vectors(input logic use_gaps);
    logic gap;
    int   waited;
    for (int i = 0; i < num_vec; i++) begin
      @(negedge clk);
      in_valid = 1'b1;
      dut_in   = {vec_mem[4*i], vec_mem[4*i+1], vec_mem[4*i+2]};
      waited   = 0;
      while (!in_ready && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!in_ready) stop_on_timeout("in_ready");
      exp_q.push_back(vec_mem[4*i+3][15:0]);
      @(posedge clk);  // Transfer edge
      if (use_gaps) begin
        take_bit(gap);
        if (gap) begin
          @(negedge clk);
          in_valid = 1'b0;
        end
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_for_sends(input int count);
    int waited;
    waited = 0;
    @(posedge clk);
    while (sent_count < count && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (sent_count < count) stop_on_timeout("output words");
  endtask

  task automatic wait_for_stall();
    int waited;
    waited = 0;
    @(negedge clk);
    while (in_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (in_ready) stop_on_timeout("in_ready to fall");
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    apply_reset();
  endtask

  task automatic finish_test();
    wait_for_sends(num_vec);
    credit_mode = CREDIT_PROMPT;  // All credits back so a stray word could still go out
    repeat (QUIET_CYCLES) @(posedge clk);
    check_value("word count", num_vec, sent_count);
    check_value("words outstanding", 0, exp_q.size());
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %s: %0d errors", test_name, test_errors);
  endtask

  initial begin
    rst            = 1'b1;
    in_valid       = 1'b0;
    dut_in         = '0;
    credit_return  = 1'b0;
    credit_mode    = CREDIT_NONE;
    rand_state     = 16'd15706;
    total_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_name      = "setup";
    for (int a = 0; a < 4*MAX_VEC; a++) begin
      vec_mem[a] = fill_word(a);
    end
    $readmemh("dv/rv_ctl_testdata.hex", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && vec_mem[4*num_vec] != fill_word(4*num_vec)) begin
      num_vec++;
    end
    $display("loaded %0d vectors", num_vec);
    if (num_vec == 0) begin
      report_failure("no test vectors found in the data file");
    end

    start_test("decode_in_order");
    credit_mode = CREDIT_PROMPT;
    drive_vectors(1'b0);
    finish_test();

    // No returns until both stages back up
    start_test("credit_limit");
    fork
      drive_vectors(1'b0);
      begin
        wait_for_sends(`CTL_CREDITS);
        wait_for_stall();
        check_value("words held at stall", 2, exp_q.size());  // One word per stage
        repeat (QUIET_CYCLES) @(posedge clk);
        check_value("words sent without returns", `CTL_CREDITS, sent_count);
        credit_mode = CREDIT_PROMPT;
      end
    join
    finish_test();

    start_test("random_credit");
    credit_mode = CREDIT_RANDOM;
    drive_vectors(1'b1);
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: include/ctl_config.svh
/* Control decoder configuration
   Data width, output credit depth and instruction field positions */
`ifndef CTL_CONFIG_SVH
`define CTL_CONFIG_SVH

`define XLEN        32  // Instruction and operand width
`define CTL_CREDITS 2   // Words the downstream consumer can buffer

`define OPC_LSB     0   // Opcode, 7 bits
`define F3_LSB      12  // funct3, 3 bits
`define F7_LSB      25  // funct7, 7 bits

`endif

// File: run.sh
#!/bin/sh
# Build and run the control decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f rv_ctl.f --top-module tb_rv_ctl -o tb_rv_ctl
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_rv_ctl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0

// File: rv_ctl.f
+incdir+include
design/rv_ctl_pkg.sv
design/ex_stage.sv
design/wb_stage.sv
design/credit_counter.sv
design/rv_ctl_top.sv
dv/tb_clock.sv
dv/tb_rv_ctl.sv
